/* run_sim.sh */
#!/bin/sh
# Build and run the music player testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary -j 0 -Wno-fatal --top-module music_player_tb \
        -Mdir obj_dir -f verilog.f; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vmusic_player_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

/* tb/music_model.svh */
`ifndef MUSIC_MODEL_SVH
`define MUSIC_MODEL_SVH

// ======================================================================
// Frame and beat level reference of the player
// ======================================================================

localparam int QUARTER_POINTS = 2 ** ($bits(rom_addr_t) - 2);

player_state_t song_state;
logic [3:0]    cur_pos;
int            frames_in_beat;
int            beats_left;
note_t         voice_note  [NUM_SLOTS];
phase_t        voice_phase [NUM_SLOTS];
logic [14:0]   quarter_table [QUARTER_POINTS];

task automatic read_sine_table();
    $readmemh("verilog/sine_quarter.hex", quarter_table);
endtask

// Full period from the quarter table by folding
function automatic sample_t sine_value(input rom_addr_t index);
    int quadrant;
    int offset;
    int magnitude;
    quadrant = int'(index) / QUARTER_POINTS;
    offset   = int'(index) % QUARTER_POINTS;
    // Falling quarters run backwards
    if (quadrant == 1 || quadrant == 3)
        offset = QUARTER_POINTS - 1 - offset;
    magnitude = int'(quarter_table[offset]);
    if (quadrant >= 2)
        magnitude = -magnitude;
    return sample_t'(magnitude);
endfunction

task automatic silence_voices();
    for (int s = 0; s < NUM_SLOTS; s++) begin
        voice_note[s]  = '0;
        voice_phase[s] = '0;
    end
endtask

task automatic reset_model();
    song_state     = ST_IDLE;
    cur_pos        = '0;
    frames_in_beat = 0;
    beats_left     = 0;
    silence_voices();
endtask

// Entry note goes to its slot, phase restarts
task automatic load_entry(input logic [3:0] pos);
    cur_pos        = pos;
    beats_left     = int'(SONG[pos].beats);
    frames_in_beat = 0;
    voice_note[SONG[pos].slot]  = SONG[pos].note;
    voice_phase[SONG[pos].slot] = '0;
endtask

task automatic press_play();
    case (song_state)
        ST_IDLE: begin
            load_entry(4'd0);
            song_state = ST_PLAY;
        end
        ST_PLAY: song_state = ST_PAUSE;
        default: song_state = ST_PLAY;
    endcase
endtask

// Jump to the following phrase start
task automatic press_next();
    int target;
    if (song_state != ST_IDLE) begin
        target = (int'(cur_pos) / PHRASE_LEN + 1) * PHRASE_LEN;
        if (target >= SONG_LEN)
            target = 0;
        load_entry(4'(target));
    end
endtask

task automatic count_beat();
    frames_in_beat++;
    if (frames_in_beat == BEAT_FRAMES) begin
        frames_in_beat = 0;
        beats_left--;
        if (beats_left == 0) begin
            // Last entry expired, back to idle and silence
            if (int'(cur_pos) == SONG_LEN - 1) begin
                song_state = ST_IDLE;
                cur_pos    = '0;
                silence_voices();
            end else begin
                load_entry(cur_pos + 4'd1);
            end
        end
    end
endtask

// One codec frame, expected mix when the frame is played
task automatic advance_frame(output logic sounded, output sample_t expected);
    int sum;
    sum      = 0;
    sounded  = 1'b0;
    expected = '0;
    if (song_state == ST_PLAY) begin
        sounded = 1'b1;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            voice_phase[s] = voice_phase[s] + phase_t'(int'(voice_note[s]) * STEP_SCALE);
            if (voice_note[s] != '0)
                sum += int'(sine_value(voice_phase[s][$bits(phase_t)-1 -: $bits(rom_addr_t)]));
        end
        expected = sample_t'(sum);
        // Loads from this beat show up from the next frame on
        count_beat();
    end
endtask

`endif

/* tb/music_player_tb.sv */
module music_player_tb;
    import music_pkg::*;
    import synth_pkg::*;

    localparam int NUM_FRAMES  = 600;
    localparam int MIN_GAP     = 8;
    localparam int MAX_GAP     = 15;
    // Frame to sample with all three voices contending
    localparam int MAX_LATENCY = 5;
    localparam int CYCLE_LIMIT = NUM_FRAMES * 16 + 100;
    // Idle frames before the first play
    localparam int QUIET_FRAMES = 12;

    logic       clk;
    logic       rst;
    logic       play;
    logic       next;
    logic       new_frame;
    sample_t    sample_out;
    logic       new_sample;
    logic       playing;
    logic [3:0] song_pos;

    int   cycle_count;
    logic started;

    `include "music_model.svh"

    music_player_top uut (
        .clk(clk), .rst(rst), .play(play), .next(next), .new_frame(new_frame),
        .sample_out(sample_out), .new_sample(new_sample), .playing(playing),
        .song_pos(song_pos)
    );

    always #20 clk = ~clk;

    // ======================================================================
    // Failure reporting and compare tasks
    // ======================================================================
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at time %0t", $time);
    endtask

    task automatic check_sample(input sample_t got, input sample_t exp, input string what);
        if (got !== exp)
            stop_with_failure($sformatf("Mismatch at time %0t: %s got %0d, expected %0d",
                                        $time, what, got, exp));
    endtask

    task automatic check_pos(input logic [3:0] got, input logic [3:0] exp, input string what);
        if (got !== exp)
            stop_with_failure($sformatf("Mismatch at time %0t: %s got %0d, expected %0d",
                                        $time, what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_with_failure($sformatf("Mismatch at time %0t: %s got %b, expected %b",
                                        $time, what, got, exp));
    endtask

    // Hang guard
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
            stop_with_failure($sformatf("Timeout: run went past %0d cycles", CYCLE_LIMIT));
    end

    // ======================================================================
    // Stimulus and checking
    // ======================================================================
    initial begin
        logic    sounded;
        logic    do_play;
        logic    do_next;
        logic    pulsed;
        sample_t expected;
        int      gap;
        int      waited;
        int      pick;
        clk         = 1'b0;
        rst         = 1'b1;
        play        = 1'b0;
        next        = 1'b0;
        new_frame   = 1'b0;
        cycle_count = 0;
        started     = 1'b0;
        void'($urandom(32'h7418));
        read_sine_table();
        reset_model();

        // Table peak bounds the three-voice sum
        for (int q = 0; q < QUARTER_POINTS; q++) begin
            if (int'(quarter_table[q]) > SINE_PEAK)
                stop_with_failure($sformatf("Sine table entry %0d is above the peak of %0d",
                                            q, SINE_PEAK));
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Quiet outputs straight out of reset
        check_flag(new_sample, 1'b0, "new_sample after reset");
        check_flag(playing, 1'b0, "playing after reset");
        check_sample(sample_out, '0, "sample_out after reset");

        for (int f = 0; f < NUM_FRAMES; f++) begin
            gap = MIN_GAP + int'($urandom % (MAX_GAP - MIN_GAP + 1));
            new_frame = 1'b1;
            advance_frame(sounded, expected);
            @(negedge clk);
            new_frame = 1'b0;
            waited    = 1;

            // Played frame owes exactly one sample
            if (sounded) begin
                check_flag(new_sample, 1'b0, "new_sample one cycle after frame");
                while (!new_sample && waited < MAX_LATENCY) begin
                    @(negedge clk);
                    waited++;
                end
                if (!new_sample)
                    stop_with_failure($sformatf(
                        "No new_sample within %0d cycles of a played frame", MAX_LATENCY));
                check_sample(sample_out, expected, "sample_out");
                @(negedge clk);
                waited++;
            end

            // Rare control press between this sample and the next frame
            pick    = int'($urandom % 60);
            do_play = 1'b0;
            do_next = 1'b0;
            case (song_state)
                ST_IDLE:  do_play = (f >= QUIET_FRAMES) && (pick < 10);
                ST_PAUSE: begin
                    do_play = (pick < 10);
                    do_next = (pick >= 58);
                end
                default: begin
                    do_play = (pick == 0);
                    do_next = (pick >= 58);
                end
            endcase

            pulsed = 1'b0;
            while (waited < gap) begin
                check_flag(new_sample, 1'b0, "new_sample with no frame pending");
                if (!pulsed) begin
                    play = do_play;
                    next = do_next;
                    if (do_play) begin
                        press_play();
                        started = 1'b1;
                    end
                    if (do_next)
                        press_next();
                    pulsed = 1'b1;
                end
                @(negedge clk);
                play = 1'b0;
                next = 1'b0;
                waited++;
            end

            // Position and play level settle before the next frame
            check_pos(song_pos, cur_pos, "song_pos");
            check_flag(playing, song_state == ST_PLAY, "playing");
            if (!started)
                check_sample(sample_out, '0, "sample_out before play");
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+tb
verilog/music_pkg.sv
verilog/synth_pkg.sv
verilog/sine_bus_if.sv
verilog/song_reader.sv
verilog/note_player.sv
verilog/sine_rom_arbiter.sv
verilog/sine_rom.sv
verilog/wave_mixer.sv
verilog/music_player_top.sv
tb/music_player_tb.sv

/* verilog/music_pkg.sv */
package music_pkg;

    // ======================================================================
    // Song entry fields
    // ======================================================================

    // Note number, zero is a rest
    typedef logic [5:0] note_t;
    // Duration in beats
    typedef logic [5:0] beats_t;
    // Voice index, 0 to 2
    typedef logic [1:0] slot_t;

    typedef struct packed {
        note_t  note;
        beats_t beats;
        slot_t  slot;
    } song_entry_t;

    localparam int NUM_SLOTS   = 3;
    // Codec frames per beat
    localparam int BEAT_FRAMES = 4;
    localparam int SONG_LEN    = 16;
    // Aligned group of entries, target of next
    localparam int PHRASE_LEN  = 4;

    // ======================================================================
    // Fixed song, four phrases of four entries
    // ======================================================================
    localparam song_entry_t SONG [SONG_LEN] = '{
        '{note: 6'd20, beats: 6'd2, slot: 2'd0},
        '{note: 6'd24, beats: 6'd2, slot: 2'd1},
        '{note: 6'd27, beats: 6'd3, slot: 2'd2},
        '{note: 6'd32, beats: 6'd1, slot: 2'd0},
        '{note: 6'd22, beats: 6'd2, slot: 2'd1},
        '{note: 6'd0,  beats: 6'd1, slot: 2'd2},
        '{note: 6'd29, beats: 6'd3, slot: 2'd0},
        '{note: 6'd25, beats: 6'd2, slot: 2'd2},
        '{note: 6'd18, beats: 6'd4, slot: 2'd0},
        '{note: 6'd30, beats: 6'd1, slot: 2'd1},
        '{note: 6'd34, beats: 6'd2, slot: 2'd2},
        '{note: 6'd15, beats: 6'd2, slot: 2'd1},
        '{note: 6'd26, beats: 6'd3, slot: 2'd0},
        '{note: 6'd21, beats: 6'd1, slot: 2'd2},
        '{note: 6'd36, beats: 6'd2, slot: 2'd1},
        '{note: 6'd12, beats: 6'd4, slot: 2'd0}
    };

endpackage

/* verilog/music_player_top.sv */
module music_player_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               play,
    input  logic               next,
    input  logic               new_frame,
    output synth_pkg::sample_t sample_out,
    output logic               new_sample,
    output logic               playing,
    output logic [3:0]         song_pos
);
    import music_pkg::*;
    import synth_pkg::*;

    logic frame_gate;
    logic [NUM_SLOTS-1:0] note_load;
    logic [NUM_SLOTS-1:0] voice_done;
    note_t note_value;
    sample_t voice [NUM_SLOTS];
    rom_addr_t rom_addr;
    sample_t rom_data;

    // One sine bus per voice
    sine_bus_if bus [NUM_SLOTS] ();

    // ======================================================================
    // Song sequencing
    // ======================================================================
    song_reader reader (
        .clk(clk), .rst(rst), .play(play), .next(next), .new_frame(new_frame),
        .playing(playing), .song_pos(song_pos), .frame_gate(frame_gate),
        .note_load(note_load), .note_value(note_value)
    );

    // ======================================================================
    // Voices and the shared table
    // ======================================================================
    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_voice
        note_player player (
            .clk(clk), .rst(rst), .frame(frame_gate), .load(note_load[i]),
            .note(note_value), .bus(bus[i]),
            .voice_sample(voice[i]), .done(voice_done[i])
        );
    end

    sine_rom_arbiter arbiter (
        .clk(clk), .rst(rst), .bus0(bus[0]), .bus1(bus[1]), .bus2(bus[2]),
        .rom_addr(rom_addr), .rom_data(rom_data)
    );

    sine_rom rom (.clk(clk), .addr(rom_addr), .data(rom_data));

    wave_mixer mixer (
        .clk(clk), .rst(rst), .frame(frame_gate),
        .voice0(voice[0]), .voice1(voice[1]), .voice2(voice[2]), .done(voice_done),
        .sample_out(sample_out), .new_sample(new_sample)
    );

endmodule

/* verilog/note_player.sv */
module note_player (
    input  logic                clk,
    input  logic                rst,
    input  logic                frame,
    input  logic                load,
    input  music_pkg::note_t    note,
    sine_bus_if.requester       bus,
    output synth_pkg::sample_t  voice_sample,
    output logic                done
);
    import music_pkg::*;
    import synth_pkg::*;

    note_t   note_q;
    note_t   note_eff;
    phase_t  phase;
    phase_t  phase_base;
    phase_t  phase_next;
    sample_t sample_q;
    logic    done_q;

    // A load in the frame cycle takes effect before the step
    assign note_eff   = load ? note : note_q;
    assign phase_base = load ? '0 : phase;
    assign phase_next = phase_base + phase_t'(note_eff * STEP_SCALE);

    // Value and done pass straight through on the return cycle
    assign voice_sample = bus.valid ? bus.data : sample_q;
    assign done         = done_q | bus.valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            note_q  <= '0;
            phase   <= '0;
            bus.req <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            if (load) begin
                note_q <= note;
                phase  <= '0;
            end
            if (frame) begin
                phase <= phase_next;
                if (note_eff != '0) begin
                    bus.req <= 1'b1;
                    done_q  <= 1'b0;
                end else begin
                    // Rest needs no table read
                    done_q <= 1'b1;
                end
            end else if (bus.grant) begin
                bus.req <= 1'b0;
            end
            if (bus.valid)
                done_q <= 1'b1;
        end
    end

    // Address and sample payload
    always_ff @(posedge clk) begin
        if (frame)
            bus.addr <= phase_next[$bits(phase_t)-1 -: $bits(rom_addr_t)];
        if (bus.valid)
            sample_q <= bus.data;
        else if (frame && note_eff == '0)
            sample_q <= '0;
    end

endmodule

/* verilog/sine_bus_if.sv */
interface sine_bus_if;
    import synth_pkg::*;

    // Pending read, held until grant
    logic      req;
    // Period index, stable while req is high
    rom_addr_t addr;
    // Single-cycle accept from the arbiter
    logic      grant;
    // Table value, qualified by valid
    sample_t   data;
    logic      valid;

    // Note player side
    modport requester (output req, output addr, input grant, input data, input valid);

    // Table side
    modport arbiter (input req, input addr, output grant, output data, output valid);

endinterface

/* verilog/sine_quarter.hex */
// One 15-bit magnitude per line, quarter-period index 0 to 31
00F5
02E0
04C8
06AE
088F
0A6B
0C41
0E0F
0FD4
1190
1341
14E6
167E
1808
1984
1AEF
1C4A
1D94
1ECB
1FF0
2101
21FD
22E4
23B6
2472
2517
25A6
261D
267D
26C5
26F5
270D

/* verilog/sine_rom.sv */
module sine_rom (
    input  logic                 clk,
    input  synth_pkg::rom_addr_t addr,
    output synth_pkg::sample_t   data
);
    import synth_pkg::*;

    localparam int QW = $bits(rom_addr_t) - 2;

    // First quarter of the period, magnitudes only
    logic [14:0] quarter [2**QW];
    logic [QW-1:0] idx;
    logic [14:0] mag;
    sample_t mag_s;

    initial begin
        $readmemh("verilog/sine_quarter.hex", quarter);
    end

    // ======================================================================
    // Quadrant folding
    // ======================================================================

    // Second and fourth quadrant read the table backwards
    assign idx   = addr[QW] ? ~addr[QW-1:0] : addr[QW-1:0];
    assign mag   = quarter[idx];
    assign mag_s = sample_t'({1'b0, mag});

    // Second half of the period is negative
    always_ff @(posedge clk) begin
        if (addr[QW+1])
            data <= -mag_s;
        else
            data <= mag_s;
    end

endmodule

/* verilog/sine_rom_arbiter.sv */
module sine_rom_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    sine_bus_if.arbiter          bus0,
    sine_bus_if.arbiter          bus1,
    sine_bus_if.arbiter          bus2,
    output synth_pkg::rom_addr_t rom_addr,
    input  synth_pkg::sample_t   rom_data
);
    import music_pkg::*;
    import synth_pkg::*;

    logic [NUM_SLOTS-1:0] req_vec;
    logic [NUM_SLOTS-1:0] grant_vec;
    logic [NUM_SLOTS-1:0] valid_q;
    slot_t gnt_idx;
    slot_t last_q;

    assign req_vec = {bus2.req, bus1.req, bus0.req};

    // ======================================================================
    // Round-robin pick, search starts after the last grant
    // ======================================================================
    always_comb begin
        int idx;
        grant_vec = '0;
        gnt_idx   = last_q;
        // Walk backwards so the nearest pending slot wins
        for (int i = NUM_SLOTS; i >= 1; i--) begin
            idx = (int'(last_q) + i) % NUM_SLOTS;
            if (req_vec[idx]) begin
                grant_vec      = '0;
                grant_vec[idx] = 1'b1;
                gnt_idx        = slot_t'(idx);
            end
        end
    end

    // Granted address goes to the table
    always_comb begin
        case (gnt_idx)
            2'd1:    rom_addr = bus1.addr;
            2'd2:    rom_addr = bus2.addr;
            default: rom_addr = bus0.addr;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_q  <= slot_t'(NUM_SLOTS - 1);
            valid_q <= '0;
        end else begin
            // Table answers one cycle after the grant
            valid_q <= grant_vec;
            if (|grant_vec)
                last_q <= gnt_idx;
        end
    end

    assign bus0.grant = grant_vec[0];
    assign bus1.grant = grant_vec[1];
    assign bus2.grant = grant_vec[2];

    // Data shared, valid picks the owner
    assign bus0.data  = rom_data;
    assign bus1.data  = rom_data;
    assign bus2.data  = rom_data;
    assign bus0.valid = valid_q[0];
    assign bus1.valid = valid_q[1];
    assign bus2.valid = valid_q[2];

endmodule

/* verilog/song_reader.sv */
module song_reader (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              play,
    input  logic                              next,
    input  logic                              new_frame,
    output logic                              playing,
    output logic [3:0]                        song_pos,
    output logic                              frame_gate,
    output logic [music_pkg::NUM_SLOTS-1:0]   note_load,
    output music_pkg::note_t                  note_value
);
    import music_pkg::*;
    import synth_pkg::*;

    player_state_t state;
    logic [$clog2(BEAT_FRAMES)-1:0] frame_cnt;
    beats_t beats_left;
    logic beat;
    logic last_beat;
    logic start_load;
    logic song_end;
    logic [3:0] load_pos;
    logic [3:0] phrase_next;

    // Frames reach the voices only while playing
    assign frame_gate = new_frame && (state == ST_PLAY);
    assign playing    = (state == ST_PLAY);

    assign beat      = frame_gate && (frame_cnt == BEAT_FRAMES - 1);
    assign last_beat = beat && (beats_left == beats_t'(1));

    // Start of the following phrase, wraps past the end
    assign phrase_next = 4'(((song_pos / PHRASE_LEN) + 1) * PHRASE_LEN % SONG_LEN);

    // ======================================================================
    // Which entry to load this cycle
    // ======================================================================
    always_comb begin
        start_load = 1'b0;
        song_end   = 1'b0;
        load_pos   = song_pos + 4'd1;
        case (state)
            ST_IDLE: begin
                if (play) begin
                    start_load = 1'b1;
                    load_pos   = '0;
                end
            end
            ST_PLAY, ST_PAUSE: begin
                if (next) begin
                    start_load = 1'b1;
                    load_pos   = phrase_next;
                end else if (last_beat) begin
                    // Last entry expired, song is over
                    if (song_pos == 4'(SONG_LEN - 1))
                        song_end = 1'b1;
                    else
                        start_load = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // ======================================================================
    // State, beat counting and note loading
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            song_pos   <= '0;
            frame_cnt  <= '0;
            beats_left <= '0;
            note_load  <= '0;
            note_value <= '0;
        end else begin
            note_load <= '0;
            if (frame_gate)
                frame_cnt <= beat ? '0 : frame_cnt + 1'b1;
            if (beat)
                beats_left <= beats_left - 1'b1;
            if (start_load) begin
                song_pos   <= load_pos;
                beats_left <= SONG[load_pos].beats;
                frame_cnt  <= '0;
                note_value <= SONG[load_pos].note;
                note_load  <= NUM_SLOTS'(1) << SONG[load_pos].slot;
            end
            // Silence every voice at the end
            if (song_end) begin
                song_pos   <= '0;
                note_value <= '0;
                note_load  <= '1;
            end
            if (song_end)
                state <= ST_IDLE;
            else if (play)
                state <= (state == ST_PLAY) ? ST_PAUSE : ST_PLAY;
        end
    end

endmodule

/* verilog/synth_pkg.sv */
package synth_pkg;

    // ======================================================================
    // Sample path types
    // ======================================================================

    // Signed audio sample
    typedef logic signed [15:0] sample_t;
    // Phase accumulator, top bits index one period
    typedef logic [15:0] phase_t;
    // Index into the 128-point period
    typedef logic [6:0] rom_addr_t;

    // Phase step per note number per frame, linear pitch map
    localparam int STEP_SCALE = 37;
    // Largest table magnitude
    // three voices summed stay inside sample_t
    localparam int SINE_PEAK  = 10000;

    // Song reader states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PLAY,
        ST_PAUSE
    } player_state_t;

endpackage

/* verilog/wave_mixer.sv */
module wave_mixer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            frame,
    input  synth_pkg::sample_t              voice0,
    input  synth_pkg::sample_t              voice1,
    input  synth_pkg::sample_t              voice2,
    input  logic [music_pkg::NUM_SLOTS-1:0] done,
    output synth_pkg::sample_t              sample_out,
    output logic                            new_sample
);
    import synth_pkg::*;

    logic    armed;
    sample_t mix;

    // Table peak keeps this sum in range
    assign mix = voice0 + voice1 + voice2;

    // ======================================================================
    // One sample per frame, once every voice has reported
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            armed      <= 1'b0;
            new_sample <= 1'b0;
            sample_out <= '0;
        end else begin
            new_sample <= 1'b0;
            if (frame) begin
                armed <= 1'b1;
            end else if (armed && (&done)) begin
                armed      <= 1'b0;
                sample_out <= mix;
                new_sample <= 1'b1;
            end
        end
    end

endmodule
